// File: bench/lc3b_pipe_asserts.sv
module lc3b_pipe_asserts
    import lc3b_pkg::*;
(
    input logic           clk,
    input logic           arst_n,
    input lc3b_word       instr_address,
    input lc3b_wb_t       wb,
    input lc3b_redirect_t redirect,
    input lc3b_fd_t       fd,
    input lc3b_dx_t       dx
);

    wb_known: assert property (@(posedge clk) disable iff (!arst_n)
        wb.valid |-> !$isunknown({wb.dest, wb.data}))
        else $error("wb fields unknown while wb.valid is high");

    pc_even: assert property (@(posedge clk) disable iff (!arst_n)
        !instr_address[0])
        else $error("instr_address is odd");

    // both younger instructions are squashed behind a taken branch
    redirect_flush: assert property (@(posedge clk) disable iff (!arst_n)
        redirect.taken |=> (!fd.valid && !dx.valid))
        else $error("valid instruction survived a taken redirect");

endmodule : lc3b_pipe_asserts

// File: bench/lc3b_pipe_tb.sv
module lc3b_pipe_tb
    import lc3b_pkg::*;
();

    localparam lc3b_word reset_pc = 16'h0100;

    logic        clk;
    logic        arst_n;
    lc3b_word    instr_address;
    lc3b_word    instr_rdata;
    lc3b_wb_t    wb;
    lc3b_word    prog [512];
    int unsigned prog_len;
    logic [18:0] expected_q [$];    // dest and data per writeback
    int          seed = 32'hfe899747;
    logic        watch_armed = 1'b0;
    int          watch_cycles = 0;
    int          watch_limit = 0;

    assign instr_rdata = prog[instr_address[9:1]];    // answered in the same cycle

    lc3b_pipe #(.reset_pc(reset_pc)) dut0
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .instr_address (instr_address),
        .instr_rdata   (instr_rdata),
        .wb            (wb)
    );

    bind lc3b_pipe lc3b_pipe_asserts asserts0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
            fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    function automatic void clear_memory();
        for (int i = 0; i < 512; i++)
            prog[i] = {4'hf, 3'b000, 9'(i)};    // trap opcode, a no-op here
    endfunction

    function automatic void put(lc3b_word w);
        prog[int'(reset_pc[9:1]) + prog_len] = w;
        prog_len++;
    endfunction

    // ISA interpreter, yields the writebacks in program order
    function automatic void run_model(int unsigned end_idx);
        lc3b_word regs [8];
        lc3b_word pc;
        lc3b_word ir;
        lc3b_word a;
        lc3b_word b;
        lc3b_word res;
        lc3b_nzp  cc;
        logic     wr;
        expected_q.delete();
        regs = '{default: 16'h0000};
        cc   = 3'b010;
        pc   = reset_pc;
        while (pc[9:1] != end_idx)
        begin
            ir = prog[pc[9:1]];
            pc = pc + 16'd2;
            a  = regs[ir[8:6]];
            b  = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
            wr = 1'b1;
            case (ir[15:12])
                4'b0001: res = a + b;
                4'b0101: res = a & b;
                4'b1001: res = ~a;
                4'b1101:
                begin
                    res = a >> ir[3:0];
                    if (!ir[4])
                        res = a << ir[3:0];
                    else if (ir[5] && a[15])
                        res = res | ~(16'hffff >> ir[3:0]);    // sign fill
                end
                default:
                begin
                    wr  = 1'b0;
                    res = 16'h0000;
                end
            endcase
            if (wr)
            begin
                regs[ir[11:9]] = res;
                cc = res[15] ? 3'b100 : ((res == 16'h0000) ? 3'b010 : 3'b001);
                expected_q.push_back({ir[11:9], res});
            end
            else if (ir[15:12] == 4'b0000 && (ir[11:9] & cc) != 3'b000)
                pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
        end
    endfunction

    task automatic begin_program();
        @(posedge clk);
        #1;
        arst_n   = 1'b0;    // old program stops before memory changes
        clear_memory();
        prog_len = 0;
    endtask

    task automatic finish_program();
        put({op_br, 3'b111, 9'h1ff});    // self-loop
        run_model(int'(reset_pc[9:1]) + prog_len - 1);
        watch_cycles = 0;
        watch_limit  = 16 + 8 * prog_len;
        watch_armed  = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("instr_address", instr_address, reset_pc);
        while (expected_q.size() != 0)
            @(posedge clk);
        watch_armed = 1'b0;
        repeat (20) @(posedge clk);    // any writeback now is an extra one
    endtask

    task automatic build_alu();
        put({op_add, 3'd1, 3'd0, 1'b1, 5'h07});
        put({op_add, 3'd2, 3'd0, 1'b1, 5'h10});    // -16
        put({op_add, 3'd3, 3'd1, 3'b000, 3'd2});
        put({op_and, 3'd4, 3'd3, 3'b000, 3'd1});
        put({op_and, 3'd5, 3'd2, 1'b1, 5'h1d});
        put({op_not, 3'd6, 3'd3, 6'h3f});
        put({op_not, 3'd7, 3'd6, 6'h3f});
        for (int i = 0; i < 4; i++)
            put({op_add, 3'd1, 3'd1, 3'b000, 3'd1});
        put({op_and, 3'd2, 3'd1, 1'b1, 5'h0f});
        put({op_add, 3'd3, 3'd3, 1'b1, 5'h1f});
        put({op_and, 3'd0, 3'd7, 3'b000, 3'd6});
    endtask

    task automatic build_shift();
        put({op_add, 3'd1, 3'd0, 1'b1, 5'h15});    // 0xfff5
        put({op_add, 3'd5, 3'd0, 1'b1, 5'h0d});
        put({op_shf, 3'd5, 3'd5, 2'b00, 4'd10});
        for (int amt = 0; amt < 16; amt++)
        begin
            put({op_shf, 3'd2, amt[0] ? 3'd5 : 3'd1, 2'b00, 4'(amt)});
            put({op_shf, 3'd3, amt[0] ? 3'd1 : 3'd5, 2'b01, 4'(amt)});
            put({op_shf, 3'd4, amt[1] ? 3'd5 : 3'd1, 2'b11, 4'(amt)});
        end
    endtask

    task automatic build_branch();
        for (int src = 0; src < 3; src++)
            for (int m = 0; m < 8; m++)
            begin
                case (src)
                    0: put({op_add, 3'd1, 3'd0, 1'b1, 5'h1f});
                    1: put({op_and, 3'd1, 3'd1, 1'b1, 5'h00});
                    default: put({op_add, 3'd1, 3'd0, 1'b1, 5'h01});
                endcase
                put({op_br, 3'(m), 9'h001});
                put({op_add, 3'd2, 3'd2, 1'b1, 5'h01});    // skipped when taken
            end
    endtask

    task automatic build_random(int n);
        int       r;
        int       off;
        lc3b_word w;
        for (int i = 0; i < n; i++)
        begin
            r   = $random(seed);
            off = (n - 1 - i < r[8:7]) ? n - 1 - i : r[8:7];    // stays inside
            case (r[5:4])
                2'd0: w = {op_add, r[12:10], r[15:13], r[9], r[9] ? r[20:16] : 5'(r[18:16])};
                2'd1: w = {op_and, r[12:10], r[15:13], r[9], r[9] ? r[20:16] : 5'(r[18:16])};
                2'd2: w = {op_not, r[12:10], r[15:13], 6'h3f};
                default: w = {op_shf, r[12:10], r[15:13], r[25:24], r[29:26]};
            endcase
            if (r[3:0] < 4)
                w = {op_br, r[6:4], 9'(off)};
            put(w);
        end
    endtask

    // compare process, sampled away from the rising edge
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!arst_n)
            begin
                check_value("wb.valid", wb.valid, 1'b0);
                check_value("instr_address", instr_address, reset_pc);
            end
            else if (wb.valid)
            begin
                if (expected_q.size() == 0)
                    fail_now("a writeback appeared where none was expected");
                else
                begin
                    check_value("wb.dest", wb.dest, expected_q[0][18:16]);
                    check_value("wb.data", wb.data, expected_q[0][15:0]);
                    void'(expected_q.pop_front());
                end
            end
        end
    end

    initial
    begin
        while (!(watch_armed && watch_cycles > watch_limit))
        begin
            @(posedge clk);
            if (watch_armed)
                watch_cycles++;
        end
        fail_now("timed out waiting for the expected writebacks");
    end

    initial
    begin
        arst_n = 1'b0;
        prog_len = 0;
        clear_memory();
        begin_program();
        build_alu();
        finish_program();
        begin_program();
        build_shift();
        finish_program();
        begin_program();
        build_branch();
        finish_program();
        begin_program();
        build_random(200);
        finish_program();
        $display("TEST PASSED");
        $finish;
    end

endmodule : lc3b_pipe_tb

// File: hdl/lc3b_branch.sv
module lc3b_branch
    import lc3b_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  lc3b_dx_t       dx,
    input  lc3b_word       ex_result,
    output lc3b_redirect_t redirect
);

    lc3b_nzp  nzp;
    lc3b_nzp  nzp_next;
    lc3b_word br_offset;

    // gencc
    always_comb
    begin
        if (ex_result[15])
            nzp_next = 3'b100;
        else if (ex_result == 16'h0000)
            nzp_next = 3'b010;
        else
            nzp_next = 3'b001;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            nzp <= 3'b010;    // z after reset
        end
        else if (dx.valid && dx.load_regfile)
        begin
            nzp <= nzp_next;
        end
    end

    assign br_offset = {{6{dx.offset9[8]}}, dx.offset9, 1'b0};    // adj9

    // nzp compare, resolved in execute
    assign redirect.taken  = dx.valid && dx.is_br && |(dx.nzp_mask & nzp);
    assign redirect.target = dx.pc_plus2 + br_offset;

endmodule : lc3b_branch

// File: hdl/lc3b_decode.sv
module lc3b_decode
    import lc3b_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  lc3b_fd_t       fd,
    input  lc3b_redirect_t redirect,
    output lc3b_reg        rd_a,
    output lc3b_reg        rd_b,
    input  lc3b_word       val_a,
    input  lc3b_word       val_b,
    output lc3b_dx_t       dx
);

    lc3b_opcode opcode;
    lc3b_dx_t   dx_next;
    logic       known;    // opcode in the kept subset

    assign opcode = lc3b_opcode'(fd.ir[15:12]);
    assign rd_a   = fd.ir[8:6];
    assign rd_b   = fd.ir[2:0];

    always_comb
    begin
        dx_next              = '0;
        known                = 1'b1;
        dx_next.aluop        = alu_add;
        dx_next.opnd_sel     = opnd_reg;
        dx_next.dest         = fd.ir[11:9];
        dx_next.sr1          = fd.ir[8:6];
        dx_next.sr2          = fd.ir[2:0];
        dx_next.sr1_val      = val_a;
        dx_next.sr2_val      = val_b;
        dx_next.nzp_mask     = fd.ir[11:9];
        dx_next.offset9      = fd.ir[8:0];
        dx_next.pc_plus2     = fd.pc_plus2;

        case (opcode)
            op_add, op_and:
            begin
                dx_next.load_regfile = 1'b1;
                dx_next.aluop        = (opcode == op_add) ? alu_add : alu_and;
                dx_next.opnd_sel     = fd.ir[5] ? opnd_sext5 : opnd_reg;    // imm bit
            end
            op_not:
            begin
                dx_next.load_regfile = 1'b1;
                dx_next.aluop        = alu_not;
                dx_next.opnd_sel     = opnd_sext5;
            end
            op_shf:
            begin
                dx_next.load_regfile = 1'b1;
                dx_next.opnd_sel     = opnd_zext4;
                case (fd.ir[5:4])    // bit 5 arithmetic, bit 4 right
                    2'b01:   dx_next.aluop = alu_srl;
                    2'b11:   dx_next.aluop = alu_sra;
                    default: dx_next.aluop = alu_sll;
                endcase
            end
            op_br:
            begin
                dx_next.is_br = 1'b1;
            end
            default:
            begin
                known = 1'b0;    // retires as a no-op
            end
        endcase

        case (dx_next.opnd_sel)
            opnd_sext5: dx_next.imm = {{11{fd.ir[4]}}, fd.ir[4:0]};
            opnd_zext4: dx_next.imm = {12'h000, fd.ir[3:0]};
            default:    dx_next.imm = '0;
        endcase
        if (opcode == op_not)
        begin
            dx_next.imm = 16'hffff;    // NOT is xor with all ones
        end

        dx_next.valid = fd.valid && known && !redirect.taken;
    end

    // decode to execute register
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dx.valid <= 1'b0;
        end
        else
        begin
            dx <= dx_next;
        end
    end

endmodule : lc3b_decode

// File: hdl/lc3b_execute.sv
module lc3b_execute
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  lc3b_dx_t dx,
    output lc3b_word ex_result,
    output lc3b_wb_t wb
);

    lc3b_word opnd_a;
    lc3b_word sr2_fwd;
    lc3b_word opnd_b;
    lc3b_word alu_out;
    logic     fwd_a;
    logic     fwd_b;

    // only the wb stage can be newer than the regfile read
    assign fwd_a = wb.valid && (wb.dest == dx.sr1);
    assign fwd_b = wb.valid && (wb.dest == dx.sr2);

    always_comb
    begin
        opnd_a  = fwd_a ? wb.data : dx.sr1_val;
        sr2_fwd = fwd_b ? wb.data : dx.sr2_val;

        // operand b select
        case (dx.opnd_sel)
            opnd_sext5,
            opnd_zext4: opnd_b = dx.imm;
            default:    opnd_b = sr2_fwd;
        endcase
    end

    // alu
    always_comb
    begin
        case (dx.aluop)
            alu_add: alu_out = opnd_a + opnd_b;
            alu_and: alu_out = opnd_a & opnd_b;
            alu_not: alu_out = opnd_a ^ opnd_b;
            alu_sll: alu_out = opnd_a << opnd_b[3:0];
            alu_srl: alu_out = opnd_a >> opnd_b[3:0];
            alu_sra: alu_out = lc3b_word'($signed(opnd_a) >>> opnd_b[3:0]);
            default: alu_out = opnd_a + opnd_b;
        endcase
    end

    assign ex_result = alu_out;    // to condition code logic

    // execute to writeback register
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb.valid <= 1'b0;
        end
        else
        begin
            wb.valid <= dx.valid && dx.load_regfile;
            wb.dest  <= dx.dest;
            wb.data  <= alu_out;
        end
    end

endmodule : lc3b_execute

// File: hdl/lc3b_fetch.sv
module lc3b_fetch
    import lc3b_pkg::*;
#(
    parameter lc3b_word reset_pc = 16'h0000
)
(
    input  logic           clk,
    input  logic           arst_n,
    input  lc3b_redirect_t redirect,
    input  lc3b_word       instr_rdata,
    output lc3b_word       instr_address,
    output lc3b_fd_t       fd
);

    lc3b_word pc;
    lc3b_word pc_plus2;

    assign pc_plus2      = pc + 16'd2;
    assign instr_address = pc;    // one word per cycle, no wait state

    // next pc selection
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= reset_pc;
        end
        else if (redirect.taken)
        begin
            pc <= redirect.target;    // taken branch from execute
        end
        else
        begin
            pc <= pc_plus2;
        end
    end

    // fetch to decode register
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fd.valid <= 1'b0;
        end
        else
        begin
            fd.valid    <= !redirect.taken;    // wrong-path word dropped
            fd.ir       <= instr_rdata;
            fd.pc_plus2 <= pc_plus2;
        end
    end

endmodule : lc3b_fetch

// File: hdl/lc3b_pipe.sv
module lc3b_pipe
    import lc3b_pkg::*;
#(
    parameter lc3b_word reset_pc = 16'h0000    // must be even
)
(
    input  logic     clk,
    input  logic     arst_n,
    output lc3b_word instr_address,
    input  lc3b_word instr_rdata,
    output lc3b_wb_t wb
);

    lc3b_fd_t       fd;
    lc3b_dx_t       dx;
    lc3b_redirect_t redirect;
    lc3b_reg        rd_a;
    lc3b_reg        rd_b;
    lc3b_word       val_a;
    lc3b_word       val_b;
    lc3b_word       ex_result;

    lc3b_fetch #(.reset_pc(reset_pc)) fetch0
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .redirect      (redirect),
        .instr_rdata   (instr_rdata),
        .instr_address (instr_address),
        .fd            (fd)
    );

    lc3b_decode decode0
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .fd       (fd),
        .redirect (redirect),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .val_a    (val_a),
        .val_b    (val_b),
        .dx       (dx)
    );

    lc3b_regfile regfile0
    (
        .clk    (clk),
        .arst_n (arst_n),
        .rd_a   (rd_a),
        .rd_b   (rd_b),
        .val_a  (val_a),
        .val_b  (val_b),
        .wb     (wb)    // write port
    );

    lc3b_execute execute0
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .dx        (dx),
        .ex_result (ex_result),
        .wb        (wb)
    );

    lc3b_branch branch0
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .dx        (dx),
        .ex_result (ex_result),
        .redirect  (redirect)
    );

endmodule : lc3b_pipe

// File: hdl/lc3b_pkg.sv
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;    // data, address or instruction
    typedef logic [2:0]  lc3b_reg;     // register index
    typedef logic [2:0]  lc3b_nzp;     // negative, zero, positive

    // standard LC-3b encodings, only the kept subset
    typedef enum logic [3:0]
    {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_not = 4'b1001,
        op_shf = 4'b1101
    } lc3b_opcode;

    typedef enum logic [2:0]
    {
        alu_add = 3'b000,
        alu_and = 3'b001,
        alu_not = 3'b010,    // a xor b, b is all ones
        alu_sll = 3'b011,
        alu_srl = 3'b100,
        alu_sra = 3'b101
    } lc3b_aluop;

    // source of alu operand b
    typedef enum logic [1:0]
    {
        opnd_reg   = 2'b00,
        opnd_sext5 = 2'b01,
        opnd_zext4 = 2'b10
    } lc3b_opnd_sel;

    typedef struct packed
    {
        logic     valid;
        lc3b_word ir;
        lc3b_word pc_plus2;
    } lc3b_fd_t;

    typedef struct packed
    {
        logic         valid;
        logic         is_br;
        logic         load_regfile;
        lc3b_aluop    aluop;
        lc3b_opnd_sel opnd_sel;
        lc3b_reg      dest;
        lc3b_reg      sr1;
        lc3b_reg      sr2;
        lc3b_word     sr1_val;
        lc3b_word     sr2_val;
        lc3b_word     imm;         // already extended
        lc3b_nzp      nzp_mask;
        logic [8:0]   offset9;
        lc3b_word     pc_plus2;
    } lc3b_dx_t;

    typedef struct packed
    {
        logic     valid;
        lc3b_reg  dest;
        lc3b_word data;
    } lc3b_wb_t;

    typedef struct packed
    {
        logic     taken;
        lc3b_word target;
    } lc3b_redirect_t;

endpackage : lc3b_pkg

// File: hdl/lc3b_regfile.sv
module lc3b_regfile
    import lc3b_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  lc3b_reg  rd_a,
    input  lc3b_reg  rd_b,
    output lc3b_word val_a,
    output lc3b_word val_b,
    input  lc3b_wb_t wb
);

    lc3b_word regs [8];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.valid)
        begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through, the value being written wins
    assign val_a = (wb.valid && wb.dest == rd_a) ? wb.data : regs[rd_a];
    assign val_b = (wb.valid && wb.dest == rd_b) ? wb.data : regs[rd_b];

endmodule : lc3b_regfile

// File: lc3b_pipe.f
hdl/lc3b_pkg.sv
hdl/lc3b_fetch.sv
hdl/lc3b_regfile.sv
hdl/lc3b_decode.sv
hdl/lc3b_execute.sv
hdl/lc3b_branch.sv
hdl/lc3b_pipe.sv
bench/lc3b_pipe_asserts.sv
bench/lc3b_pipe_tb.sv
